/* design/kv_geom_pkg.sv */
// sizes fixed at compile time; key 0 is reserved to mark an empty slot and never stored
package kv_geom_pkg;

  // key and value words
  localparam int key_width = 16;
  localparam int val_width = 16;

  // one slot holds a key and its value
  localparam int slot_width = key_width + val_width;
  localparam int slot_bytes = slot_width / 8;

  // slots per line, slot index in the result code
  localparam int num_slots        = 4;
  localparam int slot_index_width = $clog2(num_slots);

  // a line is the unit read from the table
  localparam int line_width = num_slots * slot_width;
  localparam int line_bytes = line_width / 8; // one write-enable bit per byte

  // table depth
  localparam int num_lines   = 64;
  localparam int index_width = $clog2(num_lines);

  // address register plus output register in the RAM
  localparam int ram_read_latency = 2;

  typedef logic [key_width-1:0]   key_t;
  typedef logic [val_width-1:0]   val_t;
  typedef logic [index_width-1:0] index_t;

endpackage

/* design/kv_cmd_pkg.sv */
// encodings assume four slots per line; the line union relies on slot 0 sitting in the low bits
package kv_cmd_pkg;

  import kv_geom_pkg::*;

  // 2-bit command
  typedef logic [1:0] opcode_t;

  localparam opcode_t op_nop    = 2'd0;
  localparam opcode_t op_search = 2'd1;
  localparam opcode_t op_insert = 2'd2;
  localparam opcode_t op_delete = 2'd3;

  // result code: {found, full, slot[1:0]}
  typedef logic [3:0] rescode_t;

  localparam int rc_found_bit = 3; // key was in the line
  localparam int rc_full_bit  = 2; // insert found no room

  // key lives in the low half of each slot
  typedef struct packed {
    val_t value;
    key_t key;
  } slot_t;

  // one table line seen two ways
  //   slots  used by the compare and by the line builder
  //   bytes  used by the masked write into the RAM
  typedef union packed {
    slot_t [num_slots-1:0]       slots;
    logic  [line_bytes-1:0][7:0] bytes;
  } line_t;

endpackage

/* design/kv_hash_stage.sv */
// first pipeline stage; opcode 0 is treated as nop and never enters the pipeline
`timescale 1ns/1ps

module kv_hash_stage
  import kv_geom_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       in_valid,
  input  logic [1:0] in_opcode,
  input  key_t       in_key,
  input  val_t       in_value,
  output logic       hs_valid,
  output logic [1:0] hs_opcode,
  output key_t       hs_key,
  output val_t       hs_value,
  output index_t     hs_index
);

  index_t fold_index;
  logic   take_cmd;

  // fold the 16-bit key down to a 6-bit line index
  assign fold_index = in_key[5:0]
                    ^ in_key[11:6]
                    ^ index_t'(in_key[15:12]); // top nibble zero-extended

  assign take_cmd = in_valid && (in_opcode != 2'd0); // drop nops here

  always_ff @(posedge clock) begin
    if (reset) begin
      hs_valid <= 1'b0;
    end else begin
      hs_valid <= take_cmd;
    end
  end

  // command payload travels beside hs_valid
  always_ff @(posedge clock) begin
    hs_opcode <= in_opcode;
    hs_key    <= in_key;
    hs_value  <= in_value;
    hs_index  <= fold_index;
  end

endmodule

/* design/kv_table_ram.sv */
// inferred table, read-first on a same-line collision, contents survive reset and start at zero
`timescale 1ns/1ps

module kv_table_ram
  import kv_geom_pkg::*;
  import kv_cmd_pkg::*;
(
  input  logic                  clock,
  input  index_t                rd_index,
  output line_t                 rd_line,
  input  logic                  wr_en,
  input  index_t                wr_index,
  input  logic [line_bytes-1:0] wr_mask,
  input  line_t                 wr_line
);

  line_t  mem [num_lines];
  index_t rd_addr_q;

  // empty table at power-up, every key zero
  initial begin
    for (int i = 0; i < num_lines; i++) begin
      mem[i] = '0;
    end
  end

  // byte-masked write through the byte view
  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int b = 0; b < line_bytes; b++) begin
        if (wr_mask[b]) begin
          mem[wr_index].bytes[b] <= wr_line.bytes[b];
        end
      end
    end
  end

  // registered address then registered data
  always_ff @(posedge clock) begin
    rd_addr_q <= rd_index;
    rd_line   <= mem[rd_addr_q]; // sees the old line if written this cycle
  end

endmodule

/* design/kv_slot_match.sv */
// compare stage; a key of zero never hits since zero marks an empty slot
`timescale 1ns/1ps

module kv_slot_match
  import kv_geom_pkg::*;
  import kv_cmd_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  line_t                       rd_line,
  input  logic                        dl_valid,
  input  opcode_t                     dl_opcode,
  input  key_t                        dl_key,
  input  val_t                        dl_value,
  input  index_t                      dl_index,
  output logic                        sm_valid,
  output opcode_t                     sm_opcode,
  output key_t                        sm_key,
  output val_t                        sm_value,
  output index_t                      sm_index,
  output logic                        sm_hit,
  output logic [slot_index_width-1:0] sm_hit_slot,
  output logic                        sm_has_empty,
  output logic [slot_index_width-1:0] sm_empty_slot,
  output val_t                        sm_hit_value
);

  logic [num_slots-1:0]        hit_vec;
  logic [num_slots-1:0]        empty_vec;
  logic                        hit_any;
  logic [slot_index_width-1:0] hit_slot;
  logic                        empty_any;
  logic [slot_index_width-1:0] empty_slot;

  // per-slot compare on the slot view
  always_comb begin
    for (int s = 0; s < num_slots; s++) begin
      hit_vec[s]   = (rd_line.slots[s].key == dl_key) && (dl_key != '0);
      empty_vec[s] = (rd_line.slots[s].key == '0);
    end
  end

  // lowest set slot wins, so scan from the top down
  always_comb begin
    hit_any    = 1'b0;
    hit_slot   = '0;
    empty_any  = 1'b0;
    empty_slot = '0;
    for (int s = num_slots - 1; s >= 0; s--) begin
      if (hit_vec[s]) begin
        hit_any  = 1'b1;
        hit_slot = slot_index_width'(s);
      end
      if (empty_vec[s]) begin
        empty_any  = 1'b1;
        empty_slot = slot_index_width'(s);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sm_valid <= 1'b0;
    end else begin
      sm_valid <= dl_valid;
    end
  end

  // decision and command travel together into the update stage
  always_ff @(posedge clock) begin
    sm_opcode     <= dl_opcode;
    sm_key        <= dl_key;
    sm_value      <= dl_value;
    sm_index      <= dl_index;
    sm_hit        <= hit_any;
    sm_hit_slot   <= hit_slot;
    sm_has_empty  <= empty_any;
    sm_empty_slot <= empty_slot;
    sm_hit_value  <= rd_line.slots[hit_slot].value; // only meaningful on a hit
  end

endmodule

/* design/kv_update_stage.sv */
// result and write-back stage; out_value returns the old value on a hit, zero otherwise
`timescale 1ns/1ps

module kv_update_stage
  import kv_geom_pkg::*;
  import kv_cmd_pkg::*;
(
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        sm_valid,
  input  opcode_t                     sm_opcode,
  input  key_t                        sm_key,
  input  val_t                        sm_value,
  input  index_t                      sm_index,
  input  logic                        sm_hit,
  input  logic [slot_index_width-1:0] sm_hit_slot,
  input  logic                        sm_has_empty,
  input  logic [slot_index_width-1:0] sm_empty_slot,
  input  val_t                        sm_hit_value,
  output logic                        out_valid,
  output rescode_t                    out_rescode,
  output val_t                        out_value,
  output key_t                        out_key,
  output logic                        wr_en,
  output index_t                      wr_index,
  output logic [line_bytes-1:0]       wr_mask,
  output line_t                       wr_line
);

  logic [slot_index_width-1:0] slot_sel;
  rescode_t                    rescode_d;
  logic                        write_d;
  logic                        clear_d;
  line_t                       line_d;

  always_comb begin
    slot_sel  = sm_hit ? sm_hit_slot : sm_empty_slot; // existing key before a fresh slot
    rescode_d = '0;
    write_d   = 1'b0;
    clear_d   = 1'b0;
    case (sm_opcode)
      op_search: begin
        rescode_d[rc_found_bit] = sm_hit;
        rescode_d[slot_index_width-1:0] = sm_hit ? sm_hit_slot : '0;
      end
      op_insert: begin
        if (sm_hit || sm_has_empty) begin
          write_d = 1'b1;
          rescode_d[rc_found_bit] = sm_hit;
          rescode_d[slot_index_width-1:0] = slot_sel;
        end else begin
          rescode_d[rc_full_bit] = 1'b1; // line full, nothing written
        end
      end
      op_delete: begin
        if (sm_hit) begin
          write_d = 1'b1;
          clear_d = 1'b1;
          rescode_d[rc_found_bit] = 1'b1;
          rescode_d[slot_index_width-1:0] = sm_hit_slot;
        end
      end
      default: ;
    endcase
    // same pair in every slot, the mask picks one
    for (int s = 0; s < num_slots; s++) begin
      line_d.slots[s].key   = clear_d ? '0 : sm_key;
      line_d.slots[s].value = clear_d ? '0 : sm_value;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      wr_en     <= 1'b0;
    end else begin
      out_valid <= sm_valid;
      wr_en     <= sm_valid && write_d;
    end
  end

  always_ff @(posedge clock) begin
    out_rescode <= rescode_d;
    out_value   <= sm_hit ? sm_hit_value : '0;
    out_key     <= sm_key;
    wr_index    <= sm_index;
    wr_mask     <= line_bytes'({slot_bytes{1'b1}}) << (slot_sel * slot_bytes);
    wr_line     <= line_d;
  end

endmodule

/* design/kv_engine.sv */
// one command per cycle, 4-cycle latency, no forwarding; wait 6 cycles after a write to see it
`timescale 1ns/1ps

module kv_engine
  import kv_geom_pkg::*;
  import kv_cmd_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  input  opcode_t  in_opcode,
  input  key_t     in_key,
  input  val_t     in_value,
  output logic     out_valid,
  output rescode_t out_rescode,
  output val_t     out_value,
  output key_t     out_key
);

  logic hs_valid, dl_valid, sm_valid, sm_hit, sm_has_empty, wr_en;
  opcode_t hs_opcode, dl_opcode, sm_opcode;
  key_t hs_key, dl_key, sm_key;
  val_t hs_value, dl_value, sm_value, sm_hit_value;
  index_t hs_index, dl_index, sm_index, wr_index;
  logic [slot_index_width-1:0] sm_hit_slot, sm_empty_slot;
  logic [line_bytes-1:0] wr_mask;
  line_t rd_line, wr_line;

  // command delay line, matches the RAM read latency
  logic [ram_read_latency-1:0] dl_valid_q;
  opcode_t dl_opcode_q [ram_read_latency];
  key_t    dl_key_q    [ram_read_latency];
  val_t    dl_value_q  [ram_read_latency];
  index_t  dl_index_q  [ram_read_latency];

  kv_hash_stage u_hash (.clock, .reset, .in_valid, .in_opcode, .in_key, .in_value,
                        .hs_valid, .hs_opcode, .hs_key, .hs_value, .hs_index);

  kv_table_ram u_ram (.clock, .rd_index(hs_index), .rd_line,
                      .wr_en, .wr_index, .wr_mask, .wr_line);

  always_ff @(posedge clock) begin
    if (reset) begin
      dl_valid_q <= '0;
    end else begin
      dl_valid_q <= {dl_valid_q[ram_read_latency-2:0], hs_valid};
    end
  end

  always_ff @(posedge clock) begin
    dl_opcode_q[0] <= hs_opcode;
    dl_key_q[0]    <= hs_key;
    dl_value_q[0]  <= hs_value;
    dl_index_q[0]  <= hs_index;
    for (int i = 1; i < ram_read_latency; i++) begin
      dl_opcode_q[i] <= dl_opcode_q[i-1];
      dl_key_q[i]    <= dl_key_q[i-1];
      dl_value_q[i]  <= dl_value_q[i-1];
      dl_index_q[i]  <= dl_index_q[i-1];
    end
  end

  assign dl_valid  = dl_valid_q[ram_read_latency-1]; // lines up with rd_line
  assign dl_opcode = dl_opcode_q[ram_read_latency-1];
  assign dl_key    = dl_key_q[ram_read_latency-1];
  assign dl_value  = dl_value_q[ram_read_latency-1];
  assign dl_index  = dl_index_q[ram_read_latency-1];

  kv_slot_match u_match (.clock, .reset, .rd_line, .dl_valid, .dl_opcode, .dl_key,
                         .dl_value, .dl_index, .sm_valid, .sm_opcode, .sm_key,
                         .sm_value, .sm_index, .sm_hit, .sm_hit_slot, .sm_has_empty,
                         .sm_empty_slot, .sm_hit_value);

  kv_update_stage u_update (.clock, .reset, .sm_valid, .sm_opcode, .sm_key, .sm_value,
                            .sm_index, .sm_hit, .sm_hit_slot, .sm_has_empty,
                            .sm_empty_slot, .sm_hit_value, .out_valid, .out_rescode,
                            .out_value, .out_key, .wr_en, .wr_index, .wr_mask, .wr_line);

endmodule

/* bench/kv_engine_tb.sv */
// run from the project root so the data file resolves; results must come back in issue order
`timescale 1ns/1ps

module kv_engine_tb
  import kv_geom_pkg::*;
  import kv_cmd_pkg::*;
();

  localparam int max_rows     = 64;
  localparam int row_words    = 7; // test, gap, opcode, key, value, rescode, expected value
  localparam int max_tests    = 16;
  localparam int latency      = 4;
  localparam int clock_period = 40;
  localparam int drive_delay  = 2;
  localparam logic [15:0] end_mark    = 16'hffff; // rows past the end keep this
  localparam logic [15:0] random_mark = 16'hffff; // value column asks for a random value
  localparam int unsigned rng_seed    = 32'hda04_d214;

  typedef struct {
    int       test_num;
    key_t     key;
    rescode_t rescode;
    val_t     value;
    int       issue_cycle;
  } expect_t;

  logic     clock;
  logic     reset;
  logic     in_valid;
  opcode_t  in_opcode;
  key_t     in_key;
  val_t     in_value;
  logic     out_valid;
  rescode_t out_rescode;
  val_t     out_value;
  key_t     out_key;

  logic [15:0] table_words [max_rows*row_words];
  expect_t     expect_q [$];
  int          rows_left [max_tests];
  logic        test_bad [max_tests];
  int          num_rows;
  int          cycle_count = 0;
  int          cycle_limit = 0; // zero until the data file is loaded
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          other_errors = 0;

  kv_engine dut (.clock, .reset, .in_valid, .in_opcode, .in_key, .in_value,
                 .out_valid, .out_rescode, .out_value, .out_key);

  function automatic string test_name(int num);
    case (num)
      1: return "empty_search";
      2: return "insert_search";
      3: return "filler_insert";
      4: return "collide_full";
      5: return "update_delete";
      6: return "back_to_back";
      default: return $sformatf("test_%0d", num);
    endcase
  endfunction

  function automatic logic [15:0] row_field(int row, int col);
    return table_words[row*row_words + col];
  endfunction

  initial begin
    clock = 1'b0;
    forever #(clock_period/2) clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // watchdog
  always @(negedge clock) begin
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d results never arrived",
               cycle_count, expect_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  task automatic report_test(int num);
    if (test_bad[num]) begin
      $display("test %0d %s: FAIL", num, test_name(num));
      tests_failed++;
    end else begin
      $display("test %0d %s: PASS", num, test_name(num));
      tests_passed++;
    end
  endtask

  task automatic check_result();
    expect_t e;
    string   name;
    logic    bad;
    int      seen_latency;
    if (expect_q.size() == 0) begin
      $display("result for key %h came out with no command waiting for it", out_key);
      other_errors++;
    end else begin
      e            = expect_q.pop_front();
      name         = test_name(e.test_num);
      bad          = 1'b0;
      seen_latency = cycle_count - e.issue_cycle;
      assert (out_key == e.key) else begin
        $display("MISMATCH %s key: expected %h, actual %h", name, e.key, out_key);
        bad = 1'b1;
      end
      assert (out_rescode == e.rescode) else begin
        $display("MISMATCH %s key %h rescode: expected %h, actual %h",
                 name, e.key, e.rescode, out_rescode);
        bad = 1'b1;
      end
      assert (out_value == e.value) else begin
        $display("MISMATCH %s key %h value: expected %h, actual %h",
                 name, e.key, e.value, out_value);
        bad = 1'b1;
      end
      assert (seen_latency == latency) else begin
        $display("MISMATCH %s key %h latency: expected %0d, actual %0d",
                 name, e.key, latency, seen_latency);
        bad = 1'b1;
      end
      if (bad) begin
        test_bad[e.test_num] = 1'b1;
      end
      rows_left[e.test_num]--;
      if (rows_left[e.test_num] == 0) begin
        report_test(e.test_num);
      end
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clock) begin
    if (out_valid) begin
      check_result();
    end
  end

  task automatic issue_row(int row);
    expect_t e;
    int      gap;
    gap = int'(row_field(row, 1));
    if (gap < 1) begin
      gap = 1;
    end
    in_opcode = opcode_t'(row_field(row, 2));
    in_key    = key_t'(row_field(row, 3));
    if (row_field(row, 4) == random_mark) begin
      in_value = val_t'($urandom);
    end else begin
      in_value = val_t'(row_field(row, 4));
    end
    in_valid = 1'b1;
    if (in_opcode != op_nop) begin // nops give no result
      e.test_num    = int'(row_field(row, 0));
      e.key         = in_key;
      e.rescode     = rescode_t'(row_field(row, 5));
      e.value       = val_t'(row_field(row, 6));
      e.issue_cycle = cycle_count + 1; // taken on the next edge
      expect_q.push_back(e);
    end
    repeat (gap) begin
      @(posedge clock);
      #drive_delay;
      in_valid = 1'b0;
    end
  endtask

  initial begin
    int tnum;
    int gap_sum;
    void'($urandom(rng_seed));
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_opcode = op_nop;
    in_key    = '0;
    in_value  = '0;
    for (int i = 0; i < max_rows*row_words; i++) begin
      table_words[i] = end_mark;
    end
    for (int t = 0; t < max_tests; t++) begin
      rows_left[t] = 0;
      test_bad[t]  = 1'b0;
    end
    $readmemh("bench/kv_testdata.txt", table_words);

    num_rows = 0;
    gap_sum  = 0;
    while (num_rows < max_rows && row_field(num_rows, 0) != end_mark) begin
      tnum = int'(row_field(num_rows, 0));
      if (tnum >= max_tests) begin
        $display("data file row %0d has test number %0d, rest of file ignored",
                 num_rows, tnum);
        other_errors++;
        break;
      end
      if (row_field(num_rows, 2) != 16'h0) begin
        rows_left[tnum]++;
      end
      gap_sum += (int'(row_field(num_rows, 1)) < 1) ? 1 : int'(row_field(num_rows, 1));
      num_rows++;
    end
    if (num_rows == 0) begin
      $display("no commands could be read from the data file");
      other_errors++;
    end
    cycle_limit = gap_sum + latency * num_rows + 20;

    repeat (2) @(posedge clock);
    #drive_delay;
    reset = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      issue_row(r);
    end

    while (expect_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (latency) @(negedge clock); // catch any late extra result

    $display("tests passed %0d, tests failed %0d, other errors %0d",
             tests_passed, tests_failed, other_errors);
    if (tests_failed == 0 && other_errors == 0 && tests_passed > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* bench/kv_testdata.txt */
// test gap opcode key value exp_rescode exp_value, all hex; value ffff means pick at random
// opcode 0 nop, 1 search, 2 insert, 3 delete; gap is cycles until the next command
1 1 1 0123 0000 0 0000
1 1 1 0000 0000 0 0000
2 6 2 0123 beef 0 0000
2 1 1 0123 0000 8 beef
3 1 2 0010 ffff 0 0000
3 1 2 0020 ffff 0 0000
3 1 2 0030 ffff 0 0000
4 6 2 0003 1111 0 0000
4 6 2 0042 2222 1 0000
4 6 2 1002 3333 2 0000
4 6 2 0081 4444 3 0000
4 6 2 2001 5555 4 0000
4 6 1 2001 0000 0 0000
4 6 1 1002 0000 a 3333
5 6 2 0042 6666 9 2222
5 6 1 0042 0000 9 6666
5 6 3 0003 0000 8 1111
5 6 1 0003 0000 0 0000
5 6 3 0003 0000 0 0000
5 6 2 2001 7777 0 0000
5 6 1 2001 0000 8 7777
6 1 1 0123 0000 8 beef
6 1 1 0081 0000 b 4444
6 1 0 0123 0000 0 0000
6 1 1 0042 0000 9 6666
6 1 1 0555 0000 0 0000
6 1 1 1002 0000 a 3333

/* tb.f */
design/kv_geom_pkg.sv
design/kv_cmd_pkg.sv
design/kv_hash_stage.sv
design/kv_table_ram.sv
design/kv_slot_match.sv
design/kv_update_stage.sv
design/kv_engine.sv
bench/kv_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module kv_engine_tb -f tb.f -o kv_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/kv_sim); then
  printf '%s\n' "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed!'; then
  exit 0
else
  exit 1
fi
